// File: gps_time_base.sv
`timescale 1ns/1ns

module gps_time_base import tdma_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        pps,
    input  logic        tick,
    input  utc_sec_t    utc_sec,
    output tick_count_t pps_count,
    output time_stamp_t now
);

    utc_sec_t    utc_q;
    tick_count_t tick_cnt;
    // pps_count as seen at the previous tick
    tick_count_t last_pps;

    ////////////////////////////////////////////////////////////////////////////
    // second pulse counter and utc latch
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pps_count <= '0;
            utc_q     <= '0;
        end else if (pps) begin
            pps_count <= pps_count + 1'b1;
            utc_q     <= utc_sec;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ticks inside the current second
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tick_cnt <= '0;
            last_pps <= '0;
        end else if (tick) begin
            if (pps_count != last_pps) begin
                // first tick of a new second
                last_pps <= pps_count;
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign now = '{sec: utc_q, ticks: tick_cnt};

endmodule

// File: payload_writer.sv
`timescale 1ns/1ns
`include "tdma_defs.svh"

module payload_writer import tdma_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start,
    input  payload_t   payload,
    output wb_master_t wb,
    input  logic       wb_ack,
    output logic       done
);

    localparam int WORD_W = $clog2(`TDMA_PAYLOAD_WORDS);
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`TDMA_PAYLOAD_WORDS - 1);

    wb_state_e         state;
    logic [WORD_W-1:0] word_idx;
    payload_t          payload_q;
    wb_addr_t          word_addr;
    wb_data_t          word_data;
    logic              bus_active;

    always_ff @(posedge clk) begin
        if (start && (state == WB_IDLE)) begin
            payload_q <= payload;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // classic write sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= WB_IDLE;
            word_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                WB_IDLE: begin
                    if (start) begin
                        word_idx <= '0;
                        state    <= WB_REQ;
                    end
                end
                WB_REQ: begin
                    // hold the word until the slave acks
                    if (wb_ack) begin
                        state <= WB_GAP;
                    end
                end
                WB_GAP: begin
                    if (word_idx == LAST_WORD) begin
                        done  <= 1'b1;
                        state <= WB_IDLE;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        state    <= WB_REQ;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // word order is type, seq, sec, ticks
    always_comb begin
        case (word_idx)
            2'd0:    word_data = wb_data_t'(payload_q.pkt_type);
            2'd1:    word_data = payload_q.seq;
            2'd2:    word_data = payload_q.stamp.sec;
            default: word_data = payload_q.stamp.ticks;
        endcase
    end

    assign word_addr  = `TDMA_PAYLOAD_ADDR + wb_addr_t'({word_idx, 2'b00});
    assign bus_active = (state == WB_REQ);

    assign wb = '{cyc: bus_active, stb: bus_active, we: bus_active,
                  adr: word_addr, dat_w: word_data};

endmodule

// File: ping_control.sv
`timescale 1ns/1ns
`include "tdma_defs.svh"

module ping_control import tdma_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start_ping,
    input  logic        open_loop,
    input  rx_msg_t     rx,
    input  time_stamp_t now,
    input  logic        tx_enable,
    input  logic        write_done,
    output logic        write_start,
    output payload_t    payload,
    output logic        send_pkt,
    output seq_t        res_seq,
    output tick_count_t res_delta_t
);

    ping_state_e state;
    pkt_type_e   pkt_type_q;
    seq_t        seq_q;
    time_stamp_t stamp_q;
    // ack-ping as received for the round trip math
    rx_msg_t     ack_q;

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && !start_ping && !rx.ping && rx.ack_ping) begin
            ack_q <= rx;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ping / ack-ping engine
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            pkt_type_q  <= PKT_PING;
            seq_q       <= '0;
            stamp_q     <= '0;
            write_start <= 1'b0;
            send_pkt    <= 1'b0;
            res_seq     <= '0;
            res_delta_t <= '0;
        end else begin
            write_start <= 1'b0;
            send_pkt    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_ping) begin
                        state <= ST_WAIT_TXEN;
                    end else if (rx.ping) begin
                        // echo the sender's seq and stamp
                        pkt_type_q <= PKT_ACK_PING;
                        seq_q      <= rx.seq;
                        stamp_q    <= rx.stamp;
                        state      <= ST_WRITE;
                    end else if (rx.ack_ping) begin
                        state <= ST_PROCESS_ACK;
                    end
                end
                ST_WAIT_TXEN: begin
                    if (tx_enable) begin
                        pkt_type_q  <= PKT_PING;
                        seq_q       <= seq_t'(1);
                        stamp_q     <= now;
                        res_seq     <= '0;
                        res_delta_t <= '0;
                        state       <= ST_WRITE;
                    end
                end
                ST_PROCESS_ACK: begin
                    res_seq <= ack_q.seq;
                    if (ack_q.stamp.sec == now.sec) begin
                        res_delta_t <= now.ticks - ack_q.stamp.ticks;
                    end else begin
                        res_delta_t <= now.ticks + `TDMA_TICKS_WRAP - ack_q.stamp.ticks;
                    end
                    if (open_loop) begin
                        pkt_type_q <= PKT_PING;
                        seq_q      <= seq_q + 1'b1;
                        stamp_q    <= now;
                        state      <= ST_WRITE;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    write_start <= 1'b1;
                    state       <= ST_WAIT_DONE;
                end
                ST_WAIT_DONE: begin
                    if (write_done) begin
                        send_pkt <= 1'b1;
                        state    <= ST_FINISH;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    assign payload = '{pkt_type: pkt_type_q, seq: seq_q, stamp: stamp_q};

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_tdma -o sim_tdma

# tee keeps the log even when the simulator exits with an error
./obj_dir/sim_tdma | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi

// File: slot_timer.sv
`timescale 1ns/1ns
`include "tdma_defs.svh"

module slot_timer import tdma_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        tick,
    input  tick_count_t pps_count,
    input  logic        tdma_enable,
    input  slot_idx_t   bch_slot,
    output slot_idx_t   slot_index,
    output logic        tx_enable
);

    localparam slot_tick_t LAST_TICK = slot_tick_t'(`TDMA_SLOT_TICKS - 1);
    localparam slot_idx_t  LAST_SLOT = slot_idx_t'(`TDMA_FRAME_SLOTS - 1);

    slot_tick_t  slot_tick;
    // own copy keeps the slot clear independent of the time base
    tick_count_t last_pps;

    ////////////////////////////////////////////////////////////////////////////
    // slot tick counter and frame slot index
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_tick  <= '0;
            slot_index <= '0;
            last_pps   <= '0;
        end else if (tick) begin
            if (pps_count != last_pps) begin
                // second pulse realigns the frame
                last_pps   <= pps_count;
                slot_tick  <= '0;
                slot_index <= '0;
            end else if (slot_tick == LAST_TICK) begin
                slot_tick <= '0;
                if (slot_index == LAST_SLOT) begin
                    slot_index <= '0;
                end else begin
                    slot_index <= slot_index + 1'b1;
                end
            end else begin
                slot_tick <= slot_tick + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // transmit gate
    ////////////////////////////////////////////////////////////////////////////
    // slot 0 is reserved, so bch_slot of 0 means no own slot
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_enable <= 1'b1;
        end else begin
            tx_enable <= !tdma_enable || ((bch_slot != '0) && (bch_slot == slot_index));
        end
    end

endmodule

// File: tb.f
+incdir+.
tdma_pkg.sv
gps_time_base.sv
slot_timer.sv
payload_writer.sv
ping_control.sv
tdma_top.sv
tdma_sva.sv
tb_tdma.sv

// File: tb_tdma.sv
`timescale 1ns/1ns
`include "tdma_defs.svh"

module tb_tdma import tdma_pkg::*; ();

    localparam int RAND_CYCLES = 4000;
    // enough ticks for one full frame wrap
    localparam int WRAP_CYCLES = 101000;
    localparam int TRIALS = 25;
    localparam int TRIAL_BUDGET = 100;
    localparam int TIMEOUT_CYCLES = RAND_CYCLES + WRAP_CYCLES + TRIALS * TRIAL_BUDGET + 1000;

    logic        clk;
    logic        reset_n;
    logic        pps;
    logic        tick;
    utc_sec_t    utc_sec;
    logic        tdma_enable;
    slot_idx_t   bch_slot;
    logic        start_ping;
    logic        open_loop;
    rx_msg_t     rx;
    logic        wb_ack;
    wb_master_t  wb;
    slot_idx_t   slot_index;
    logic        tx_enable;
    seq_t        res_seq;
    tick_count_t res_delta_t;
    logic        send_pkt;
    tick_count_t pps_count;

    // model state
    tick_count_t m_pps_count;
    tick_count_t m_last_pps;
    utc_sec_t    m_utc;
    tick_count_t m_ticks;
    int          m_slot_tick;
    slot_idx_t   m_slot;
    logic        m_txen;
    seq_t        last_seq;

    wb_addr_t    wr_adr_q [$];
    wb_data_t    wr_dat_q [$];
    int          send_cnt;
    int          ack_wait;
    int          cycle_cnt = 0;
    bit          result_shown = 1'b0;

    tdma_top dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model of the time base, slot timer and gate
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!reset_n) begin
            m_pps_count <= '0;
            m_last_pps  <= '0;
            m_utc       <= '0;
            m_ticks     <= '0;
            m_slot_tick <= 0;
            m_slot      <= '0;
            m_txen      <= 1'b1;
        end else begin
            if (pps) begin
                m_pps_count <= m_pps_count + 32'd1;
                m_utc       <= utc_sec;
            end
            m_txen <= !tdma_enable || ((bch_slot != '0) && (bch_slot == m_slot));
            if (tick) begin
                if (m_pps_count != m_last_pps) begin
                    m_last_pps  <= m_pps_count;
                    m_ticks     <= '0;
                    m_slot_tick <= 0;
                    m_slot      <= '0;
                end else begin
                    m_ticks <= m_ticks + 32'd1;
                    if (m_slot_tick == `TDMA_SLOT_TICKS - 1) begin
                        m_slot_tick <= 0;
                        m_slot <= (m_slot == slot_idx_t'(`TDMA_FRAME_SLOTS - 1)) ?
                                  '0 : slot_idx_t'(m_slot + 16'd1);
                    end else begin
                        m_slot_tick <= m_slot_tick + 1;
                    end
                end
            end
        end
    end

    // wishbone slave with random ack delay
    initial begin
        wb_ack   = 1'b0;
        ack_wait = 0;
        send_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (send_pkt) begin
                send_cnt++;
            end
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb.cyc && wb.stb) begin
                if (ack_wait == 0) begin
                    check_we(wb.we);
                    wr_adr_q.push_back(wb.adr);
                    wr_dat_q.push_back(wb.dat_w);
                    wb_ack   = 1'b1;
                    ack_wait = $urandom_range(0, 3);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles waiting for the DUT", cycle_cnt);
            result_shown = 1'b1;
            $display("Test failed");
            $fatal(1);
        end
    end

    final begin
        if (!result_shown) begin
            $display("Test failed");
        end
    end

    task automatic abort_run();
        result_shown = 1'b1;
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_slot(input slot_idx_t got, input slot_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] slot_index got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_gate(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] tx_enable got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_pps_count(input tick_count_t got, input tick_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] pps_count got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_we(input logic got);
        if (got !== 1'b1) begin
            $display("[ERROR] wb.we got %h expected %h", got, 1'b1);
            abort_run();
        end
    endtask

    task automatic check_word(input wb_addr_t got_adr, input wb_addr_t exp_adr,
                              input wb_data_t got_dat, input wb_data_t exp_dat);
        if (got_adr !== exp_adr) begin
            $display("[ERROR] wb.adr got %h expected %h", got_adr, exp_adr);
            abort_run();
        end
        if (got_dat !== exp_dat) begin
            $display("[ERROR] wb.dat_w got %h expected %h", got_dat, exp_dat);
            abort_run();
        end
    endtask

    task automatic check_seq(input seq_t got, input seq_t exp);
        if (got !== exp) begin
            $display("[ERROR] res_seq got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_delta(input tick_count_t got, input tick_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] res_delta_t got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    // one clock then compare the counter outputs
    task automatic step();
        @(posedge clk);
        #1;
        check_slot(slot_index, m_slot);
        check_gate(tx_enable, m_txen);
        check_pps_count(pps_count, m_pps_count);
    endtask

    task automatic run_ticks(input int cycles, input int tick_pct, input int pps_odds,
                             input bit vary_gate);
        int i;
        for (i = 0; i < cycles; i++) begin
            step();
            tick    = ($urandom_range(1, 100) <= tick_pct);
            pps     = (pps_odds != 0) && ($urandom_range(1, pps_odds) == 1);
            utc_sec = $urandom;
            if (vary_gate && (i % 2000 == 0)) begin
                tdma_enable = ($urandom_range(0, 3) != 0);
                bch_slot = ($urandom_range(0, 4) == 0) ? '0 :
                           slot_idx_t'((m_slot + $urandom_range(0, 3)) % `TDMA_FRAME_SLOTS);
            end
        end
        tick = 1'b0;
        pps  = 1'b0;
        repeat (2) step();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // payload and round trip checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic expect_payload(input pkt_type_e exp_type, input seq_t exp_seq,
                                  input time_stamp_t exp_stamp);
        wb_data_t exp_words [4];
        int       i;
        exp_words[0] = wb_data_t'(exp_type);
        exp_words[1] = exp_seq;
        exp_words[2] = exp_stamp.sec;
        exp_words[3] = exp_stamp.ticks;
        while (send_cnt == 0) begin
            step();
        end
        if (wr_adr_q.size() != `TDMA_PAYLOAD_WORDS) begin
            $display("expected four bus writes before send_pkt, saw %0d", wr_adr_q.size());
            abort_run();
        end
        for (i = 0; i < `TDMA_PAYLOAD_WORDS; i++) begin
            check_word(wr_adr_q[i], `TDMA_PAYLOAD_ADDR + wb_addr_t'(4 * i),
                       wr_dat_q[i], exp_words[i]);
        end
        repeat (4) step();
        if (send_cnt != 1) begin
            $display("send_pkt pulsed %0d times for one payload", send_cnt);
            abort_run();
        end
        wr_adr_q.delete();
        wr_dat_q.delete();
        send_cnt = 0;
        last_seq = exp_seq;
    endtask

    task automatic send_ping();
        time_stamp_t stamp;
        stamp = '{sec: m_utc, ticks: m_ticks};
        start_ping = 1'b1;
        step();
        start_ping = 1'b0;
        expect_payload(PKT_PING, seq_t'(1), stamp);
        check_seq(res_seq, '0);
        check_delta(res_delta_t, '0);
    endtask

    task automatic echo_ping();
        rx_msg_t msg;
        msg             = '0;
        msg.ping        = 1'b1;
        msg.seq         = $urandom;
        msg.stamp.sec   = $urandom;
        msg.stamp.ticks = $urandom;
        rx = msg;
        step();
        rx = '0;
        expect_payload(PKT_ACK_PING, msg.seq, msg.stamp);
    endtask

    task automatic take_ack(input bit same_sec, input bit loop_on);
        rx_msg_t     msg;
        tick_count_t exp_delta;
        time_stamp_t stamp;
        stamp        = '{sec: m_utc, ticks: m_ticks};
        msg          = '0;
        msg.ack_ping = 1'b1;
        msg.seq      = $urandom;
        if (same_sec) begin
            msg.stamp.sec   = m_utc;
            msg.stamp.ticks = $urandom_range(0, m_ticks);
            exp_delta       = m_ticks - msg.stamp.ticks;
        end else begin
            msg.stamp.sec   = m_utc - utc_sec_t'($urandom_range(1, 50));
            msg.stamp.ticks = $urandom_range(0, 999999);
            exp_delta       = m_ticks + `TDMA_TICKS_WRAP - msg.stamp.ticks;
        end
        open_loop = loop_on;
        rx = msg;
        step();
        rx = '0;
        step();
        check_seq(res_seq, msg.seq);
        check_delta(res_delta_t, exp_delta);
        if (loop_on) begin
            expect_payload(PKT_PING, last_seq + 32'd1, stamp);
        end else begin
            repeat (4) step();
            if ((send_cnt != 0) || (wr_adr_q.size() != 0)) begin
                $display("ack-ping without open loop started a payload write");
                abort_run();
            end
        end
        open_loop = 1'b0;
    endtask

    initial begin
        int n;
        void'($urandom(44966));
        reset_n     = 1'b0;
        pps         = 1'b0;
        tick        = 1'b0;
        utc_sec     = '0;
        tdma_enable = 1'b0;
        bch_slot    = '0;
        start_ping  = 1'b0;
        open_loop   = 1'b0;
        rx          = '0;
        last_seq    = '0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        run_ticks(RAND_CYCLES, 50, 1500, 1'b1);
        run_ticks(WRAP_CYCLES, 100, 0, 1'b1);

        // pings run with the gate open
        tdma_enable = 1'b0;
        for (n = 0; n < 4; n++) begin
            run_ticks(30, 50, 10, 1'b0);
            send_ping();
        end
        for (n = 0; n < 6; n++) begin
            run_ticks(30, 50, 10, 1'b0);
            echo_ping();
        end
        for (n = 0; n < 8; n++) begin
            run_ticks(30, 50, 10, 1'b0);
            take_ack(n % 2 == 0, 1'b0);
        end
        for (n = 0; n < 6; n++) begin
            run_ticks(30, 50, 10, 1'b0);
            take_ack(n % 2 == 1, 1'b1);
        end

        // a new ping clears the round trip results left by the acks
        run_ticks(30, 50, 10, 1'b0);
        send_ping();

        result_shown = 1'b1;
        $display("Test passed");
        $finish;
    end

endmodule

// File: tdma_defs.svh
`ifndef TDMA_DEFS_SVH
`define TDMA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// slot and frame geometry
////////////////////////////////////////////////////////////////////////////

// microsecond ticks per slot
`define TDMA_SLOT_TICKS 1000

// slots per frame
`define TDMA_FRAME_SLOTS 100

// added to the delta when the round trip crosses a second
`define TDMA_TICKS_WRAP 32'd999999

////////////////////////////////////////////////////////////////////////////
// packet buffer
////////////////////////////////////////////////////////////////////////////

`define TDMA_BUF_BASE 32'h0001_0000

// 30 byte mac header plus 2 bytes of padding
`define TDMA_PAYLOAD_ADDR (`TDMA_BUF_BASE + 32'h0000_0020)

`define TDMA_PAYLOAD_WORDS 4

`endif

// File: tdma_pkg.sv
package tdma_pkg;

    typedef logic [31:0] utc_sec_t;
    typedef logic [31:0] tick_count_t;
    typedef logic [15:0] slot_idx_t;
    typedef logic [9:0]  slot_tick_t;
    typedef logic [31:0] seq_t;
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    typedef enum logic [5:0] {
        PKT_PING     = 6'd1,
        PKT_ACK_PING = 6'd2
    } pkt_type_e;

    // ping engine control states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_TXEN,
        ST_PROCESS_ACK,
        ST_WRITE,
        ST_WAIT_DONE,
        ST_FINISH
    } ping_state_e;

    // wishbone write sequencer states
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_GAP
    } wb_state_e;

    typedef struct packed {
        utc_sec_t    sec;
        tick_count_t ticks;
    } time_stamp_t;

    typedef struct packed {
        pkt_type_e   pkt_type;
        seq_t        seq;
        time_stamp_t stamp;
    } payload_t;

    typedef struct packed {
        logic        ping;
        logic        ack_ping;
        seq_t        seq;
        time_stamp_t stamp;
    } rx_msg_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat_w;
    } wb_master_t;

endpackage

// File: tdma_sva.sv
`timescale 1ns/1ns

module tdma_sva import tdma_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input wb_master_t wb,
    input logic       wb_ack,
    input logic       send_pkt,
    input logic       tdma_enable,
    input logic       tx_enable
);

    // bus cycle ends in the cycle after the ack
    cyc_drops_after_ack: assert property (@(posedge clk) disable iff (!reset_n)
        (wb.stb && wb_ack) |=> (!wb.cyc && !wb.stb))
        else $error("wb cycle still open after ack");

    // request held until the slave acks
    req_held: assert property (@(posedge clk) disable iff (!reset_n)
        (wb.stb && !wb_ack) |=> $stable(wb))
        else $error("wb request changed before ack");

    send_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        send_pkt |=> !send_pkt)
        else $error("send_pkt high for more than one cycle");

    // gate forced open without tdma
    gate_open: assert property (@(posedge clk) disable iff (!reset_n)
        !tdma_enable |=> tx_enable)
        else $error("tx_enable low while tdma disabled");

endmodule

bind tdma_top tdma_sva u_sva (
    .clk         (clk),
    .reset_n     (reset_n),
    .wb          (wb),
    .wb_ack      (wb_ack),
    .send_pkt    (send_pkt),
    .tdma_enable (tdma_enable),
    .tx_enable   (tx_enable)
);

// File: tdma_top.sv
`timescale 1ns/1ns

module tdma_top import tdma_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        pps,
    input  logic        tick,
    input  utc_sec_t    utc_sec,
    input  logic        tdma_enable,
    input  slot_idx_t   bch_slot,
    input  logic        start_ping,
    input  logic        open_loop,
    input  rx_msg_t     rx,
    input  logic        wb_ack,
    output wb_master_t  wb,
    output slot_idx_t   slot_index,
    output logic        tx_enable,
    output seq_t        res_seq,
    output tick_count_t res_delta_t,
    output logic        send_pkt,
    output tick_count_t pps_count
);

    time_stamp_t now;
    payload_t    payload;
    logic        write_start;
    logic        write_done;

    gps_time_base u_time_base (
        .clk       (clk),
        .reset_n   (reset_n),
        .pps       (pps),
        .tick      (tick),
        .utc_sec   (utc_sec),
        .pps_count (pps_count),
        .now       (now)
    );

    slot_timer u_slot_timer (
        .clk         (clk),
        .reset_n     (reset_n),
        .tick        (tick),
        .pps_count   (pps_count),
        .tdma_enable (tdma_enable),
        .bch_slot    (bch_slot),
        .slot_index  (slot_index),
        .tx_enable   (tx_enable)
    );

    ping_control u_ping_control (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_ping  (start_ping),
        .open_loop   (open_loop),
        .rx          (rx),
        .now         (now),
        .tx_enable   (tx_enable),
        .write_done  (write_done),
        .write_start (write_start),
        .payload     (payload),
        .send_pkt    (send_pkt),
        .res_seq     (res_seq),
        .res_delta_t (res_delta_t)
    );

    payload_writer u_payload_writer (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (write_start),
        .payload (payload),
        .wb      (wb),
        .wb_ack  (wb_ack),
        .done    (write_done)
    );

endmodule
